// ==== hw/adc_emul_config.svh ====
`ifndef ADC_EMUL_CONFIG_SVH
`define ADC_EMUL_CONFIG_SVH

// data path widths
`define ADC_BYTE_W 8
`define ADC_SAMPLE_W 16
`define ADC_LANES 4
`define ADC_WORD_W 64

// host register width
`define ADC_REG_W 32

// over-range stretch counter, msb set gives a hold of 16 cycles
`define ADC_OR_HOLD 5

// reset values of the settings
`define ADC_DEF_REFLENGTH 60000
`define ADC_DEF_STROBE_LEN 630
`define ADC_DEF_SOA_LEN 8

`endif

// ==== hw/adc_emul_pkg.sv ====
`include "adc_emul_config.svh"

package adc_emul_pkg;

  // host register map
  typedef enum logic [3:0] {
    REG_REFLENGTH   = 4'd1,
    REG_RUN         = 4'd2,
    REG_STROBE_LEN  = 4'd3,
    REG_SOA_LEN     = 4'd4,
    REG_FIFO_RESET  = 4'd5,
    REG_FIFO_FULL   = 4'd6,
    REG_LAST_SAMPLE = 4'd8,
    REG_OVER_RANGE  = 4'd9
  } reg_addr_e;

  // address 5 on the read side returns the word address
  localparam reg_addr_e REG_WORD_ADDR = REG_FIFO_RESET;

  // single-cycle host write
  typedef struct packed {
    logic                  valid;
    reg_addr_e             addr;
    logic [`ADC_REG_W-1:0] data;
  } reg_wr_t;

  // settings seen by the pulse timer and the packer
  typedef struct packed {
    logic                  run;
    logic [`ADC_REG_W-1:0] reflength;
    logic [`ADC_REG_W-1:0] strobe_len;
    logic [`ADC_REG_W-1:0] soa_len;
  } pulse_cfg_t;

  // already captured DDR halves
  typedef struct packed {
    logic [`ADC_BYTE_W-1:0] rise;
    logic [`ADC_BYTE_W-1:0] fall;
  } ddr_byte_t;

  typedef enum logic [$clog2(`ADC_LANES)-1:0] {LANE0, LANE1, LANE2, LANE3} lane_e;

endpackage

// ==== hw/adc_ddr_sampler.sv ====
`timescale 1ns/1ps
`include "adc_emul_config.svh"

module adc_ddr_sampler (
  input  logic                     clk,
  input  logic                     reset,
  input  adc_emul_pkg::ddr_byte_t  i_ddr,
  input  logic                     i_or_rise,
  input  logic                     i_or_fall,
  output logic [`ADC_SAMPLE_W-1:0] o_sample,
  output logic                     o_over_range
);

  // capture stage
  adc_emul_pkg::ddr_byte_t ddr_q;
  // second stage, both halves of one pair stay together
  logic [`ADC_BYTE_W-1:0] rise_d;
  logic [`ADC_BYTE_W-1:0] fall_d;
  logic [`ADC_SAMPLE_W-1:0] glued;
  logic or_rise_q;
  logic or_fall_q;
  logic [`ADC_OR_HOLD-1:0] or_count;

  always_ff @(posedge clk)
  begin
    ddr_q    <= i_ddr;
    rise_d   <= ddr_q.rise;
    fall_d   <= ddr_q.fall;
    o_sample <= glued;
  end

  // rise bits land on the odd positions, fall bits on the even ones
  always_comb
  begin
    for (int k = 0; k < `ADC_BYTE_W; k++)
    begin
      glued[2*k+1] = rise_d[k];
      glued[2*k]   = fall_d[k];
    end
  end

  // stretch: load msb on any over-range, count up until it wraps to zero
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      or_rise_q    <= 1'b0;
      or_fall_q    <= 1'b0;
      or_count     <= '0;
      o_over_range <= 1'b0;
    end
    else
    begin
      or_rise_q <= i_or_rise;
      or_fall_q <= i_or_fall;
      if (or_rise_q || or_fall_q)
        or_count <= {1'b1, {(`ADC_OR_HOLD-1){1'b0}}};
      else if (or_count[`ADC_OR_HOLD-1])
        or_count <= or_count + 1'b1;
      o_over_range <= or_count[`ADC_OR_HOLD-1];
    end
  end

  // flag never shorter than the hold
  a_or_hold: assert property (@(posedge clk) disable iff (!reset)
    $rose(o_over_range) |-> o_over_range [*16]);

endmodule

// ==== hw/adc_emul_regs.sv ====
`timescale 1ns/1ps
`include "adc_emul_config.svh"

module adc_emul_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  adc_emul_pkg::reg_wr_t      i_reg_wr,
  input  adc_emul_pkg::reg_addr_e    i_rd_addr,
  input  logic [`ADC_REG_W-1:0]      i_word_addr,
  input  logic                       i_fifo_full,
  input  logic [`ADC_SAMPLE_W-1:0]   i_last_sample,
  input  logic                       i_over_range,
  output adc_emul_pkg::pulse_cfg_t   o_cfg,
  output logic                       o_fifo_reset,
  output logic [`ADC_REG_W-1:0]      o_rd_data
);

  logic wr_fifo_reset;

  // a write to address 5 carries no data, only the reset request
  assign wr_fifo_reset = i_reg_wr.valid &&
                         (i_reg_wr.addr == adc_emul_pkg::REG_FIFO_RESET);

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      o_cfg.run        <= 1'b0;
      o_cfg.reflength  <= `ADC_DEF_REFLENGTH;
      o_cfg.strobe_len <= `ADC_DEF_STROBE_LEN;
      o_cfg.soa_len    <= `ADC_DEF_SOA_LEN;
      o_fifo_reset     <= 1'b0;
    end
    else
    begin
      o_fifo_reset <= wr_fifo_reset;
      if (i_reg_wr.valid)
      begin
        case (i_reg_wr.addr)
          adc_emul_pkg::REG_REFLENGTH:
            o_cfg.reflength <= i_reg_wr.data;
          // any non-zero value starts the emulator
          adc_emul_pkg::REG_RUN:
            o_cfg.run <= |i_reg_wr.data;
          adc_emul_pkg::REG_STROBE_LEN:
            o_cfg.strobe_len <= i_reg_wr.data;
          adc_emul_pkg::REG_SOA_LEN:
            o_cfg.soa_len <= i_reg_wr.data;
          default:
            o_cfg <= o_cfg;
        endcase
      end
    end
  end

  // readback, one cycle behind the address
  always_ff @(posedge clk)
  begin
    case (i_rd_addr)
      adc_emul_pkg::REG_REFLENGTH:
        o_rd_data <= o_cfg.reflength;
      adc_emul_pkg::REG_RUN:
        o_rd_data <= `ADC_REG_W'(o_cfg.run);
      adc_emul_pkg::REG_STROBE_LEN:
        o_rd_data <= o_cfg.strobe_len;
      adc_emul_pkg::REG_SOA_LEN:
        o_rd_data <= o_cfg.soa_len;
      adc_emul_pkg::REG_WORD_ADDR:
        o_rd_data <= i_word_addr;
      adc_emul_pkg::REG_FIFO_FULL:
        o_rd_data <= `ADC_REG_W'(i_fifo_full);
      adc_emul_pkg::REG_LAST_SAMPLE:
        o_rd_data <= `ADC_REG_W'(i_last_sample);
      adc_emul_pkg::REG_OVER_RANGE:
        o_rd_data <= `ADC_REG_W'(i_over_range);
      default:
        o_rd_data <= '0;
    endcase
  end

  // host strobes are single cycle, so the reset pulse is too
  a_fifo_reset_pulse: assert property (@(posedge clk) disable iff (!reset)
    o_fifo_reset |=> !o_fifo_reset);

endmodule

// ==== hw/laser_pulse_timer.sv ====
`timescale 1ns/1ps
`include "adc_emul_config.svh"

module laser_pulse_timer (
  input  logic                     clk,
  input  logic                     reset,
  input  adc_emul_pkg::pulse_cfg_t i_cfg,
  output logic                     o_strobe,
  output logic                     o_soa
);

  logic [`ADC_REG_W-1:0] ref_cnt;
  logic [`ADC_REG_W-1:0] strobe_cnt;
  logic [`ADC_REG_W-1:0] soa_cnt;

  always_ff @(posedge clk)
  begin
    if (!reset || !i_cfg.run)
    begin
      ref_cnt    <= '0;
      strobe_cnt <= '0;
      soa_cnt    <= '0;
      o_strobe   <= 1'b0;
      o_soa      <= 1'b0;
    end
    else if (ref_cnt == i_cfg.reflength)
    begin
      // period wrap fires both pulses
      ref_cnt    <= '0;
      strobe_cnt <= '0;
      soa_cnt    <= '0;
      o_strobe   <= 1'b1;
      o_soa      <= 1'b1;
    end
    else
    begin
      ref_cnt <= ref_cnt + 1'b1;

      // counter stops once past the length, output drops
      if (strobe_cnt <= i_cfg.strobe_len)
      begin
        strobe_cnt <= strobe_cnt + 1'b1;
        o_strobe   <= 1'b1;
      end
      else
        o_strobe <= 1'b0;

      if (soa_cnt <= i_cfg.soa_len)
      begin
        soa_cnt <= soa_cnt + 1'b1;
        o_soa   <= 1'b1;
      end
      else
        o_soa <= 1'b0;
    end
  end

  // both pulses start on the same edge
  a_pulses_aligned: assert property (@(posedge clk) disable iff (!reset)
    $rose(o_strobe) |-> $rose(o_soa));

endmodule

// ==== hw/sample_packer.sv ====
`timescale 1ns/1ps
`include "adc_emul_config.svh"

module sample_packer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_run,
  input  logic [`ADC_SAMPLE_W-1:0] i_sample,
  input  logic                     i_fifo_full,
  output logic                     o_fifo_wr_en,
  output logic [`ADC_WORD_W-1:0]   o_fifo_data,
  output logic [`ADC_REG_W-1:0]    o_word_addr
);

  adc_emul_pkg::lane_e lane;
  logic                last_lane;

  assign last_lane = (lane == adc_emul_pkg::LANE3);

  // lane control, address and write strobe
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      lane         <= adc_emul_pkg::LANE0;
      o_fifo_wr_en <= 1'b0;
      o_word_addr  <= '0;
    end
    else if (!i_run)
    begin
      lane         <= adc_emul_pkg::LANE0;
      o_fifo_wr_en <= 1'b0;
    end
    else
    begin
      lane <= adc_emul_pkg::lane_e'(lane + 1'b1);
      // word is complete after lane 3, a full FIFO just loses it
      o_fifo_wr_en <= last_lane && !i_fifo_full;
      if (last_lane)
        o_word_addr <= o_word_addr + 1'b1;
    end
  end

  // earliest sample sits in the low lane
  always_ff @(posedge clk)
  begin
    if (i_run)
      o_fifo_data[int'(lane) * `ADC_SAMPLE_W +: `ADC_SAMPLE_W] <= i_sample;
  end

  // a written word was filled on four running cycles
  a_whole_word: assert property (@(posedge clk) disable iff (!reset)
    o_fifo_wr_en |-> $past(i_run, 4));

endmodule

// ==== hw/adc_emul_top.sv ====
`timescale 1ns/1ps
`include "adc_emul_config.svh"

module adc_emul_top (
  input  logic                     clk,
  input  logic                     reset,
  input  adc_emul_pkg::ddr_byte_t  i_ddr,
  input  logic                     i_or_rise,
  input  logic                     i_or_fall,
  input  adc_emul_pkg::reg_wr_t    i_reg_wr,
  input  adc_emul_pkg::reg_addr_e  i_rd_addr,
  input  logic                     i_fifo_full,
  output logic                     o_fifo_wr_en,
  output logic [`ADC_WORD_W-1:0]   o_fifo_data,
  output logic                     o_fifo_reset,
  output logic [`ADC_REG_W-1:0]    o_rd_data,
  output logic                     o_strobe,
  output logic                     o_soa
);

  logic [`ADC_SAMPLE_W-1:0]  sample;
  logic                      over_range;
  adc_emul_pkg::pulse_cfg_t  cfg;
  logic [`ADC_REG_W-1:0]     word_addr;

  adc_ddr_sampler adc_ddr_sampler_i (
    .clk          (clk),
    .reset        (reset),
    .i_ddr        (i_ddr),
    .i_or_rise    (i_or_rise),
    .i_or_fall    (i_or_fall),
    .o_sample     (sample),
    .o_over_range (over_range)
  );

  adc_emul_regs adc_emul_regs_i (
    .clk           (clk),
    .reset         (reset),
    .i_reg_wr      (i_reg_wr),
    .i_rd_addr     (i_rd_addr),
    .i_word_addr   (word_addr),
    .i_fifo_full   (i_fifo_full),
    .i_last_sample (sample),
    .i_over_range  (over_range),
    .o_cfg         (cfg),
    .o_fifo_reset  (o_fifo_reset),
    .o_rd_data     (o_rd_data)
  );

  laser_pulse_timer laser_pulse_timer_i (
    .clk      (clk),
    .reset    (reset),
    .i_cfg    (cfg),
    .o_strobe (o_strobe),
    .o_soa    (o_soa)
  );

  // packer only needs the run bit
  sample_packer sample_packer_i (
    .clk          (clk),
    .reset        (reset),
    .i_run        (cfg.run),
    .i_sample     (sample),
    .i_fifo_full  (i_fifo_full),
    .o_fifo_wr_en (o_fifo_wr_en),
    .o_fifo_data  (o_fifo_data),
    .o_word_addr  (word_addr)
  );

endmodule

// ==== bench/adc_emul_tb.sv ====
`timescale 1ns/1ps
`include "adc_emul_config.svh"

module adc_emul_tb;

  // the whole sequence needs well under a thousand cycles
  localparam int MAX_CYCLES = 20000;

  logic                     clk;
  logic                     reset;
  adc_emul_pkg::ddr_byte_t  ddr;
  logic                     or_rise;
  logic                     or_fall;
  adc_emul_pkg::reg_wr_t    reg_wr;
  adc_emul_pkg::reg_addr_e  rd_addr;
  logic                     fifo_full;
  logic                     fifo_wr_en;
  logic [`ADC_WORD_W-1:0]   fifo_data;
  logic                     fifo_reset;
  logic [`ADC_REG_W-1:0]    rd_data;
  logic                     strobe;
  logic                     soa;

  int                       seed;
  int                       cycles;
  logic [`ADC_SAMPLE_W-1:0] sample_cnt;

  // expected register contents, word position and over-range history
  logic                     exp_run;
  logic [`ADC_REG_W-1:0]    exp_reflength;
  logic [`ADC_REG_W-1:0]    exp_strobe_len;
  logic [`ADC_REG_W-1:0]    exp_soa_len;
  logic [1:0]               exp_lane;
  logic [`ADC_REG_W-1:0]    exp_word_addr;
  logic [`ADC_REG_W-1:0]    exp_rd_data;
  logic                     rd_checked;
  logic                     word_done;
  logic                     fifo_reset_req;
  logic [17:0]              or_hist;

  // pulse shape trackers
  int unsigned              strobe_hi;
  int unsigned              soa_hi;
  int unsigned              since_rise;
  int unsigned              rises;
  logic                     strobe_rise;

  adc_emul_top adc_emul_top_i (
    .clk          (clk),
    .reset        (reset),
    .i_ddr        (ddr),
    .i_or_rise    (or_rise),
    .i_or_fall    (or_fall),
    .i_reg_wr     (reg_wr),
    .i_rd_addr    (rd_addr),
    .i_fifo_full  (fifo_full),
    .o_fifo_wr_en (fifo_wr_en),
    .o_fifo_data  (fifo_data),
    .o_fifo_reset (fifo_reset),
    .o_rd_data    (rd_data),
    .o_strobe     (strobe),
    .o_soa        (soa)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // odd sample bits travel on the rise byte, even bits on the fall byte
  function automatic adc_emul_pkg::ddr_byte_t split_sample(input logic [15:0] value);
    adc_emul_pkg::ddr_byte_t pair;
    for (int k = 0; k < `ADC_BYTE_W; k++)
    begin
      pair.rise[k] = value[2*k+1];
      pair.fall[k] = value[2*k];
    end
    return pair;
  endfunction

  function automatic logic [15:0] join_pair(input adc_emul_pkg::ddr_byte_t pair);
    logic [15:0] value;
    for (int k = 0; k < `ADC_BYTE_W; k++)
    begin
      value[2*k+1] = pair.rise[k];
      value[2*k]   = pair.fall[k];
    end
    return value;
  endfunction

  task automatic stop_on_mismatch(input string what);
    $display("[FAIL] %0t ns: %s", $time, what);
    $display("Verification failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic write_reg(input adc_emul_pkg::reg_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    reg_wr.valid = 1'b1;
    reg_wr.addr  = addr;
    reg_wr.data  = data;
    @(negedge clk);
    reg_wr.valid = 1'b0;
  endtask

  task automatic read_reg(input adc_emul_pkg::reg_addr_e addr);
    @(negedge clk);
    rd_addr = addr;
    repeat (2) @(negedge clk);
  endtask

  // consecutive samples count up by one
  always @(negedge clk)
  begin
    sample_cnt = sample_cnt + 16'd1;
    ddr        = split_sample(sample_cnt);
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  // register writes land on the next edge
  always @(posedge clk)
  begin
    if (!reset)
    begin
      exp_run        <= 1'b0;
      exp_reflength  <= `ADC_DEF_REFLENGTH;
      exp_strobe_len <= `ADC_DEF_STROBE_LEN;
      exp_soa_len    <= `ADC_DEF_SOA_LEN;
    end
    else if (reg_wr.valid)
    begin
      case (reg_wr.addr)
        adc_emul_pkg::REG_REFLENGTH:  exp_reflength  <= reg_wr.data;
        adc_emul_pkg::REG_RUN:        exp_run        <= (reg_wr.data != 32'd0);
        adc_emul_pkg::REG_STROBE_LEN: exp_strobe_len <= reg_wr.data;
        adc_emul_pkg::REG_SOA_LEN:    exp_soa_len    <= reg_wr.data;
        default:                      exp_run        <= exp_run;
      endcase
    end
  end

  // one word completes every fourth running cycle
  always @(posedge clk)
  begin
    if (!reset)
    begin
      exp_lane      <= 2'd0;
      exp_word_addr <= '0;
    end
    else if (!exp_run)
      exp_lane <= 2'd0;
    else
    begin
      exp_lane <= exp_lane + 2'd1;
      if (exp_lane == 2'd3)
        exp_word_addr <= exp_word_addr + 32'd1;
    end
  end

  assign word_done      = exp_run && (exp_lane == 2'd3);
  assign fifo_reset_req = reg_wr.valid && (reg_wr.addr == adc_emul_pkg::REG_FIFO_RESET);

  always_comb
  begin
    rd_checked = 1'b1;
    case (rd_addr)
      adc_emul_pkg::REG_REFLENGTH:  exp_rd_data = exp_reflength;
      adc_emul_pkg::REG_RUN:        exp_rd_data = {31'd0, exp_run};
      adc_emul_pkg::REG_STROBE_LEN: exp_rd_data = exp_strobe_len;
      adc_emul_pkg::REG_SOA_LEN:    exp_rd_data = exp_soa_len;
      adc_emul_pkg::REG_WORD_ADDR:  exp_rd_data = exp_word_addr;
      adc_emul_pkg::REG_FIFO_FULL:  exp_rd_data = {31'd0, fifo_full};
      adc_emul_pkg::REG_OVER_RANGE: exp_rd_data = {31'd0, |or_hist[17:2]};
      default:
      begin
        exp_rd_data = '0;
        rd_checked  = 1'b0;
      end
    endcase
  end

  // flag is due 3 to 18 cycles after any over-range input
  always @(posedge clk)
  begin
    if (!reset)
      or_hist <= '0;
    else
      or_hist <= {or_hist[16:0], or_rise || or_fall};
  end

  assign strobe_rise = strobe && (strobe_hi == 0);

  always @(posedge clk)
  begin
    if (!reset || !exp_run)
    begin
      strobe_hi  <= 0;
      soa_hi     <= 0;
      since_rise <= 0;
      rises      <= 0;
    end
    else
    begin
      strobe_hi  <= strobe ? strobe_hi + 1 : 0;
      soa_hi     <= soa ? soa_hi + 1 : 0;
      since_rise <= strobe_rise ? 1 : since_rise + 1;
      if (strobe_rise)
        rises <= rises + 1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !reset |=> (!strobe && !soa && !fifo_wr_en && !fifo_reset))
    else stop_on_mismatch("outputs not low after reset");

  a_readback: assert property (@(posedge clk) disable iff (!reset)
    $past(rd_checked) |-> rd_data == $past(exp_rd_data))
    else stop_on_mismatch($sformatf("readback 0x%08h, expected 0x%08h",
                                    rd_data, $past(exp_rd_data)));

  a_fifo_reset: assert property (@(posedge clk) disable iff (!reset)
    fifo_reset == $past(fifo_reset_req))
    else stop_on_mismatch("FIFO reset pulse does not follow the write to address 5");

  a_write_enable: assert property (@(posedge clk) disable iff (!reset)
    fifo_wr_en == $past(word_done && !fifo_full))
    else stop_on_mismatch("FIFO write enable wrong for word end and full level");

  a_word_lanes: assert property (@(posedge clk) disable iff (!reset)
    fifo_wr_en |-> (fifo_data[15:0] == join_pair($past(ddr, 7))) &&
                   (fifo_data[31:16] == join_pair($past(ddr, 6))) &&
                   (fifo_data[47:32] == join_pair($past(ddr, 5))) &&
                   (fifo_data[63:48] == join_pair($past(ddr, 4))) &&
                   (fifo_data[31:16] == fifo_data[15:0] + 16'd1) &&
                   (fifo_data[47:32] == fifo_data[31:16] + 16'd1) &&
                   (fifo_data[63:48] == fifo_data[47:32] + 16'd1))
    else stop_on_mismatch($sformatf("packed word 0x%016h", fifo_data));

  // only steady periods are checked, the first pulse after run starts is short
  a_period: assert property (@(posedge clk) disable iff (!reset)
    (strobe_rise && rises >= 2) |-> since_rise == exp_reflength + 32'd1)
    else stop_on_mismatch($sformatf("strobe period %0d cycles", since_rise));

  a_strobe_len: assert property (@(posedge clk) disable iff (!reset)
    (!strobe && strobe_hi != 0 && rises >= 2) |-> strobe_hi == exp_strobe_len + 32'd2)
    else stop_on_mismatch($sformatf("strobe high for %0d cycles", strobe_hi));

  a_soa_len: assert property (@(posedge clk) disable iff (!reset)
    (!soa && soa_hi != 0 && rises >= 2) |-> soa_hi == exp_soa_len + 32'd2)
    else stop_on_mismatch($sformatf("SOA gate high for %0d cycles", soa_hi));

  a_pulses_together: assert property (@(posedge clk) disable iff (!reset)
    exp_run |-> strobe_rise == (soa && soa_hi == 0))
    else stop_on_mismatch("strobe and SOA gate did not rise together");

  a_idle_outputs: assert property (@(posedge clk) disable iff (!reset)
    !exp_run |=> (!strobe && !soa))
    else stop_on_mismatch("strobe or SOA gate active while stopped");

  initial
  begin
    seed       = 32'h1ea0;
    cycles     = 0;
    reset      = 1'b0;
    sample_cnt = 16'd0;
    ddr        = split_sample(16'd0);
    or_rise    = 1'b0;
    or_fall    = 1'b0;
    reg_wr     = '0;
    rd_addr    = adc_emul_pkg::REG_REFLENGTH;
    fifo_full  = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b1;

    // defaults after reset
    read_reg(adc_emul_pkg::REG_REFLENGTH);
    read_reg(adc_emul_pkg::REG_RUN);
    read_reg(adc_emul_pkg::REG_STROBE_LEN);
    read_reg(adc_emul_pkg::REG_SOA_LEN);

    // random settings, then the pulse test settings
    write_reg(adc_emul_pkg::REG_STROBE_LEN, $random(seed));
    read_reg(adc_emul_pkg::REG_STROBE_LEN);
    write_reg(adc_emul_pkg::REG_SOA_LEN, $random(seed));
    read_reg(adc_emul_pkg::REG_SOA_LEN);
    write_reg(adc_emul_pkg::REG_REFLENGTH, $random(seed));
    read_reg(adc_emul_pkg::REG_REFLENGTH);
    write_reg(adc_emul_pkg::REG_FIFO_RESET, 32'd0);
    repeat (3) @(negedge clk);
    write_reg(adc_emul_pkg::REG_REFLENGTH, 32'd40);
    write_reg(adc_emul_pkg::REG_STROBE_LEN, 32'd5);
    write_reg(adc_emul_pkg::REG_SOA_LEN, 32'd2);
    read_reg(adc_emul_pkg::REG_FIFO_FULL);

    // capture with random back-pressure
    write_reg(adc_emul_pkg::REG_RUN, 32'd1);
    rd_addr = adc_emul_pkg::REG_WORD_ADDR;
    repeat (400)
    begin
      @(negedge clk);
      fifo_full = (($random(seed) & 3) == 0);
    end

    // full FIFO, words dropped while the address moves on
    fifo_full = 1'b1;
    repeat (120) @(negedge clk);
    fifo_full = 1'b0;
    repeat (20) @(negedge clk);

    write_reg(adc_emul_pkg::REG_RUN, 32'd0);
    repeat (20) @(negedge clk);
    read_reg(adc_emul_pkg::REG_RUN);

    // single over-range, then a random burst on the fall flag
    @(negedge clk);
    rd_addr = adc_emul_pkg::REG_OVER_RANGE;
    or_rise = 1'b1;
    @(negedge clk);
    or_rise = 1'b0;
    repeat (30) @(negedge clk);
    repeat (80)
    begin
      @(negedge clk);
      or_fall = (($random(seed) & 15) == 0);
    end
    or_fall = 1'b0;
    repeat (30) @(negedge clk);

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hw
hw/adc_emul_pkg.sv
hw/adc_ddr_sampler.sv
hw/adc_emul_regs.sv
hw/laser_pulse_timer.sv
hw/sample_packer.sv
hw/adc_emul_top.sv
bench/adc_emul_tb.sv

// ==== Makefile ====
# Verilator build and run of the ADC capture emulator testbench

VERILATOR ?= verilator
TOP       ?= adc_emul_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
